/* vram_pkg.sv */
`default_nettype none

package vram_pkg;

  localparam int VRAM_AW = 17;

  typedef logic [VRAM_AW-1:0] vram_addr_t;
  typedef logic [7:0]         vram_data_t;

  // Four-phase dot cycle
  typedef logic [1:0] dot_state_t;

  localparam dot_state_t SLOT_GRANT  = 2'd0;
  localparam dot_state_t SLOT_SAMPLE = 2'd2;

  // 256 dots at two dots per byte
  localparam logic [7:0] BYTES_PER_LINE = 8'd128;

  typedef enum logic {
    REQ_CPU  = 1'b0,
    REQ_FILL = 1'b1
  } requester_t;

endpackage

`default_nettype wire

/* vdp_reg_pkg.sv */
`default_nettype none

package vdp_reg_pkg;

  // CPU port modes, palette and indirect modes are not kept
  typedef enum logic [1:0] {
    PORT_DATA = 2'd0,
    PORT_CTRL = 2'd1
  } port_mode_t;

  // Register numbers
  localparam logic [5:0] REG_VRAM_HI   = 6'd14;
  localparam logic [5:0] REG_CMD_FIRST = 6'd36;
  localparam logic [5:0] REG_DX_L      = 6'd36;
  localparam logic [5:0] REG_DY_L      = 6'd38;
  localparam logic [5:0] REG_NX_L      = 6'd40;
  localparam logic [5:0] REG_NY_L      = 6'd42;
  localparam logic [5:0] REG_CLR       = 6'd44;
  localparam logic [5:0] REG_CMD       = 6'd46;

  // Upper nibble of R46
  localparam logic [3:0] CMD_HMMV = 4'hC;

  // Bit positions in status and control bytes
  localparam logic [2:0] STAT_CE_BIT     = 3'd0;
  localparam logic [2:0] CTRL_REG_FLAG   = 3'd7;
  localparam logic [2:0] CTRL_WRITE_FLAG = 3'd6;

endpackage

`default_nettype wire

/* vram_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface vram_req_if;

  logic                 req;
  logic                 we;
  vram_pkg::vram_addr_t addr;
  vram_pkg::vram_data_t wdata;
  logic                 ack;
  vram_pkg::vram_data_t rdata;

  // Four-phase handshake, req held until ack, ack held until req drops
  modport requester (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

`default_nettype wire

/* vdp_cpu_port.sv */
`timescale 1ns/10ps
`default_nettype none

module vdp_cpu_port (
  input  wire                          reset,
  input  wire                          clk21m,
  input  wire                          req,
  output logic                         ack,
  input  wire                          wrt,
  input  wire vdp_reg_pkg::port_mode_t mode,
  input  wire [7:0]                    dbo,
  output logic [7:0]                   dbi,
  output logic                         cmd_reg_wr,
  output logic [5:0]                   cmd_reg_num,
  output logic [7:0]                   cmd_reg_data,
  input  wire                          cmd_busy,
  vram_req_if.requester                vram
);

  logic                 vreq;
  logic                 vwe;
  logic                 cpu_wait;
  logic                 second;
  logic [7:0]           first_byte;
  logic [2:0]           r14;
  vram_pkg::vram_addr_t addr;
  vram_pkg::vram_data_t wbuf;
  vram_pkg::vram_data_t rbuf;
  logic [7:0]           status;
  logic                 v_busy;
  logic                 is_data;
  logic                 ctrl_wr;
  logic                 ctrl_rd;
  logic                 addr_set;
  logic                 go;
  logic                 v_done;

  assign vram.req   = vreq;
  assign vram.we    = vwe;
  assign vram.addr  = addr;
  assign vram.wdata = wbuf;

  always_comb begin
    status = '0;
    status[vdp_reg_pkg::STAT_CE_BIT] = cmd_busy;
  end

  // --------------------
  // Request decode
  // --------------------
  assign v_busy   = vreq | vram.ack;
  assign v_done   = vreq & vram.ack;
  assign is_data  = (mode == vdp_reg_pkg::PORT_DATA);
  assign ctrl_wr  = (mode == vdp_reg_pkg::PORT_CTRL) && wrt;
  assign ctrl_rd  = (mode == vdp_reg_pkg::PORT_CTRL) && !wrt;
  assign addr_set = ctrl_wr && second && !dbo[vdp_reg_pkg::CTRL_REG_FLAG];
  // Anything that moves the address waits for the VRAM side to go idle
  assign go = req && !ack && !cpu_wait && !((is_data || addr_set) && v_busy);

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      ack        <= 1'b0;
      vreq       <= 1'b0;
      vwe        <= 1'b0;
      cpu_wait   <= 1'b0;
      second     <= 1'b0;
      r14        <= '0;
      addr       <= '0;
      cmd_reg_wr <= 1'b0;
    end else begin
      cmd_reg_wr <= 1'b0;
      if (ack && !req) begin
        ack <= 1'b0;
      end
      // Every finished VRAM access steps the address
      if (v_done) begin
        vreq <= 1'b0;
        addr <= addr + 1'b1;
        if (cpu_wait) begin
          ack      <= 1'b1;
          cpu_wait <= 1'b0;
        end
      end
      if (go) begin
        if (is_data) begin
          vreq     <= 1'b1;
          vwe      <= wrt;
          cpu_wait <= 1'b1;
        end else begin
          ack <= 1'b1;
          // Status read also restarts the byte pair
          if (ctrl_wr || ctrl_rd) begin
            second <= ctrl_wr && !second;
          end
          if (ctrl_wr && second) begin
            if (dbo[vdp_reg_pkg::CTRL_REG_FLAG]) begin
              if (dbo[5:0] == vdp_reg_pkg::REG_VRAM_HI) begin
                r14 <= first_byte[2:0];
              end
              cmd_reg_wr <= (dbo[5:0] >= vdp_reg_pkg::REG_CMD_FIRST);
            end else begin
              addr <= {r14, dbo[5:0], first_byte};
              if (!dbo[vdp_reg_pkg::CTRL_WRITE_FLAG]) begin
                vreq <= 1'b1;
                vwe  <= 1'b0;
              end
            end
          end
        end
      end
    end
  end

  // Data bytes and the read-ahead buffer
  always_ff @(posedge reset) begin
    if (go && ctrl_wr && !second) begin
      first_byte <= dbo;
    end
    if (go && ctrl_wr && second && dbo[vdp_reg_pkg::CTRL_REG_FLAG]) begin
      cmd_reg_num  <= dbo[5:0];
      cmd_reg_data <= first_byte;
    end
    if (go && is_data && wrt) begin
      wbuf <= dbo;
    end
    if (go && is_data && !wrt) begin
      dbi <= rbuf;
    end else if (go && ctrl_rd) begin
      dbi <= status;
    end
    if (v_done && !vwe) begin
      rbuf <= vram.rdata;
    end
  end

endmodule

`default_nettype wire

/* vdp_fill_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module vdp_fill_engine (
  input  wire           reset,
  input  wire           clk21m,
  input  wire           cmd_reg_wr,
  input  wire [5:0]     cmd_reg_num,
  input  wire [7:0]     cmd_reg_data,
  output logic          cmd_busy,
  vram_req_if.requester vram
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_DROP
  } fill_state_t;

  fill_state_t state;
  logic [7:0]  dx;
  logic [7:0]  dy;
  logic [7:0]  nx;
  logic [7:0]  ny;
  logic [7:0]  clr;
  logic [7:0]  row;
  logic [6:0]  col;
  logic [6:0]  x_left;
  logic [7:0]  y_left;
  logic        start;

  assign start = cmd_reg_wr && !cmd_busy && (cmd_reg_num == vdp_reg_pkg::REG_CMD) &&
                 (cmd_reg_data[7:4] == vdp_reg_pkg::CMD_HMMV);

  // Two dots per byte, so columns are DX/2
  assign vram.req   = (state == F_REQ);
  assign vram.we    = 1'b1;
  assign vram.wdata = clr;
  assign vram.addr  = vram_pkg::vram_addr_t'(row) *
                      vram_pkg::vram_addr_t'(vram_pkg::BYTES_PER_LINE) +
                      vram_pkg::vram_addr_t'(col);

  // Parameters stay frozen while a fill runs
  always_ff @(posedge reset) begin
    if (cmd_reg_wr && !cmd_busy) begin
      case (cmd_reg_num)
        vdp_reg_pkg::REG_DX_L: dx  <= cmd_reg_data;
        vdp_reg_pkg::REG_DY_L: dy  <= cmd_reg_data;
        vdp_reg_pkg::REG_NX_L: nx  <= cmd_reg_data;
        vdp_reg_pkg::REG_NY_L: ny  <= cmd_reg_data;
        vdp_reg_pkg::REG_CLR:  clr <= cmd_reg_data;
        default: ;
      endcase
    end
  end

  // --------------------
  // HMMV sequencer
  // --------------------
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      state    <= F_IDLE;
      cmd_busy <= 1'b0;
      row      <= '0;
      col      <= '0;
      x_left   <= '0;
      y_left   <= '0;
    end else begin
      case (state)
        F_IDLE: begin
          if (start) begin
            cmd_busy <= 1'b1;
            row      <= dy;
            col      <= dx[7:1];
            x_left   <= nx[7:1];
            y_left   <= ny;
            state    <= F_REQ;
          end
        end
        F_REQ: begin
          if (vram.ack) begin
            state <= F_DROP;
            if (x_left > 7'd1) begin
              x_left <= x_left - 7'd1;
              col    <= col + 7'd1;
            end else begin
              // End of row, back to the left edge
              x_left <= nx[7:1];
              col    <= dx[7:1];
              row    <= row + 8'd1;
              y_left <= y_left - 8'd1;
            end
          end
        end
        F_DROP: begin
          if (!vram.ack) begin
            if (y_left == 8'd0) begin
              cmd_busy <= 1'b0;
              state    <= F_IDLE;
            end else begin
              state <= F_REQ;
            end
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* vram_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module vram_arbiter (
  input  wire                       reset,
  input  wire                       clk21m,
  vram_req_if.arbiter               cpu,
  vram_req_if.arbiter               fill,
  output vram_pkg::vram_addr_t      pramadr,
  output vram_pkg::vram_data_t      pramdbo,
  input  wire vram_pkg::vram_data_t pramdbi,
  output logic                      pramwe_n
);

  vram_pkg::dot_state_t dot_state;
  vram_pkg::requester_t owner;
  logic                 active;
  logic                 ack_due;
  logic                 cpu_ack;
  logic                 fill_ack;
  vram_pkg::vram_data_t cpu_rdata;
  vram_pkg::vram_data_t fill_rdata;
  logic                 grant_slot;
  logic                 grant_cpu;
  logic                 grant_fill;
  logic                 sample;

  assign cpu.ack    = cpu_ack;
  assign cpu.rdata  = cpu_rdata;
  assign fill.ack   = fill_ack;
  assign fill.rdata = fill_rdata;

  // CPU wins the slot, the engine waits for the next one
  assign grant_slot = (dot_state == vram_pkg::SLOT_GRANT) && !active;
  assign grant_cpu  = grant_slot && cpu.req && !cpu_ack;
  assign grant_fill = grant_slot && !grant_cpu && fill.req && !fill_ack;
  assign sample     = (dot_state == vram_pkg::SLOT_SAMPLE) && active;

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      dot_state <= vram_pkg::SLOT_GRANT;
      owner     <= vram_pkg::REQ_CPU;
      active    <= 1'b0;
      ack_due   <= 1'b0;
      cpu_ack   <= 1'b0;
      fill_ack  <= 1'b0;
      pramwe_n  <= 1'b1;
    end else begin
      dot_state <= dot_state + 2'd1;
      pramwe_n  <= 1'b1;
      ack_due   <= 1'b0;
      if (grant_cpu || grant_fill) begin
        active   <= 1'b1;
        owner    <= grant_cpu ? vram_pkg::REQ_CPU : vram_pkg::REQ_FILL;
        // Write strobe lasts one cycle only
        pramwe_n <= grant_cpu ? !cpu.we : !fill.we;
      end
      if (sample) begin
        active  <= 1'b0;
        ack_due <= 1'b1;
      end
      if (ack_due) begin
        if (owner == vram_pkg::REQ_CPU) begin
          cpu_ack <= 1'b1;
        end else begin
          fill_ack <= 1'b1;
        end
      end
      if (cpu_ack && !cpu.req) begin
        cpu_ack <= 1'b0;
      end
      if (fill_ack && !fill.req) begin
        fill_ack <= 1'b0;
      end
    end
  end

  // Address, write data and read data
  always_ff @(posedge reset) begin
    if (grant_cpu) begin
      pramadr <= cpu.addr;
      pramdbo <= cpu.wdata;
    end else if (grant_fill) begin
      pramadr <= fill.addr;
      pramdbo <= fill.wdata;
    end
    if (sample && owner == vram_pkg::REQ_CPU) begin
      cpu_rdata <= pramdbi;
    end
    if (sample && owner == vram_pkg::REQ_FILL) begin
      fill_rdata <= pramdbi;
    end
  end

endmodule

`default_nettype wire

/* vdp.sv */
`timescale 1ns/10ps
`default_nettype none

module vdp (
  input  wire                       reset,
  input  wire                       clk21m,
  input  wire                       req,
  output wire                       ack,
  input  wire                       wrt,
  input  wire [1:0]                 mode,
  input  wire [7:0]                 dbo,
  output wire [7:0]                 dbi,
  output vram_pkg::vram_addr_t      pramadr,
  output vram_pkg::vram_data_t      pramdbo,
  input  wire vram_pkg::vram_data_t pramdbi,
  output wire                       pramwe_n
);

  // Command register path
  wire       cmd_reg_wr;
  wire [5:0] cmd_reg_num;
  wire [7:0] cmd_reg_data;
  wire       cmd_busy;

  vram_req_if cpu_vram ();
  vram_req_if fill_vram ();

  vdp_cpu_port i_cpu_port (
    .reset        (reset),
    .clk21m       (clk21m),
    .req          (req),
    .ack          (ack),
    .wrt          (wrt),
    .mode         (vdp_reg_pkg::port_mode_t'(mode)),
    .dbo          (dbo),
    .dbi          (dbi),
    .cmd_reg_wr   (cmd_reg_wr),
    .cmd_reg_num  (cmd_reg_num),
    .cmd_reg_data (cmd_reg_data),
    .cmd_busy     (cmd_busy),
    .vram         (cpu_vram.requester)
  );

  vdp_fill_engine i_fill_engine (
    .reset        (reset),
    .clk21m       (clk21m),
    .cmd_reg_wr   (cmd_reg_wr),
    .cmd_reg_num  (cmd_reg_num),
    .cmd_reg_data (cmd_reg_data),
    .cmd_busy     (cmd_busy),
    .vram         (fill_vram.requester)
  );

  vram_arbiter i_arbiter (
    .reset    (reset),
    .clk21m   (clk21m),
    .cpu      (cpu_vram.arbiter),
    .fill     (fill_vram.arbiter),
    .pramadr  (pramadr),
    .pramdbo  (pramdbo),
    .pramdbi  (pramdbi),
    .pramwe_n (pramwe_n)
  );

endmodule

`default_nettype wire

/* vdp_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module vdp_checker (
  input  wire       reset,
  input  wire       clk21m,
  input  wire       req,
  input  wire       ack,
  input  wire [7:0] dbi,
  input  wire       pramwe_n,
  input  wire       exp_valid,
  input  wire [7:0] exp_byte,
  output int        check_count,
  output int        error_count
);

  logic ack_q;
  logic req_q;
  logic we_low_q;

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] expected);
    error_count = error_count + 1;
    $display("ERROR %s: got 0x%h, expected 0x%h at %0t ns", name, got, expected, $time);
  endtask

  task automatic report_fault(input string what);
    error_count = error_count + 1;
    $display("Fault at %0t ns: %s", $time, what);
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
    ack_q       = 1'b0;
    req_q       = 1'b0;
    we_low_q    = 1'b0;
  end

  always @(posedge reset) begin
    if (clk21m) begin
      // Outputs while reset is held
      if (ack !== 1'b0) begin
        report_mismatch("ack", {7'd0, ack}, 8'h00);
      end
      if (pramwe_n !== 1'b1) begin
        report_mismatch("pramwe_n", {7'd0, pramwe_n}, 8'h01);
      end
      ack_q    <= 1'b0;
      req_q    <= 1'b0;
      we_low_q <= 1'b0;
    end else begin
      // --------------------
      // Four-phase rules
      // --------------------
      if (ack === 1'b1 && !ack_q && !req_q) begin
        report_fault("ack rose while req was low");
      end
      if (ack === 1'b0 && ack_q && req_q) begin
        report_fault("ack fell while req was still high");
      end
      if (pramwe_n === 1'b0 && we_low_q) begin
        report_fault("VRAM write strobe held low for more than one cycle");
      end
      // Read data is valid from the ack rise on
      if (ack === 1'b1 && !ack_q && exp_valid) begin
        check_count = check_count + 1;
        if (dbi !== exp_byte) begin
          report_mismatch("dbi", dbi, exp_byte);
        end
      end
      ack_q    <= (ack === 1'b1);
      req_q    <= req;
      we_low_q <= (pramwe_n === 1'b0);
    end
  end

endmodule

`default_nettype wire

/* tb_vdp.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_vdp;

  localparam int          STIM_LINES   = 59;
  localparam int          CLK_PERIOD   = 8;
  localparam int          DRIVE_DELAY  = 1;
  localparam int          RESET_CYCLES = 5;
  localparam logic [31:0] SEED         = 32'h7de7_149d;

  // reset is the clock, clk21m the asynchronous reset
  logic                         reset;
  logic                         clk21m;
  logic                         req;
  logic                         wrt;
  logic [1:0]                   mode;
  logic [7:0]                   dbo;
  wire                          ack;
  wire  [7:0]                   dbi;
  wire  [vram_pkg::VRAM_AW-1:0] pramadr;
  wire  [7:0]                   pramdbo;
  wire  [7:0]                   pramdbi;
  wire                          pramwe_n;

  logic [7:0]  vram_model [0:(1 << vram_pkg::VRAM_AW) - 1];
  logic [15:0] stim [0:STIM_LINES-1];
  logic        exp_valid;
  logic [7:0]  exp_byte;
  int          check_count;
  int          error_count;
  int          reads_expected;
  int          other_errors;

  vdp i_dut (
    .reset    (reset),
    .clk21m   (clk21m),
    .req      (req),
    .ack      (ack),
    .wrt      (wrt),
    .mode     (mode),
    .dbo      (dbo),
    .dbi      (dbi),
    .pramadr  (pramadr),
    .pramdbo  (pramdbo),
    .pramdbi  (pramdbi),
    .pramwe_n (pramwe_n)
  );

  vdp_checker i_checker (
    .reset       (reset),
    .clk21m      (clk21m),
    .req         (req),
    .ack         (ack),
    .dbi         (dbi),
    .pramwe_n    (pramwe_n),
    .exp_valid   (exp_valid),
    .exp_byte    (exp_byte),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    reset = 1'b0;
    forever #(CLK_PERIOD / 2) reset = ~reset;
  end

  // VRAM model, combinational read
  assign pramdbi = vram_model[pramadr];

  always @(posedge reset) begin
    if (pramwe_n === 1'b0) begin
      vram_model[pramadr] <= pramdbo;
    end
  end

  // --------------------
  // CPU bus driver
  // --------------------
  task automatic next_cycle();
    @(posedge reset);
    #DRIVE_DELAY;
  endtask

  task automatic bus_cycle(input logic is_write, input logic [1:0] port,
                           input logic [7:0] data, output logic [7:0] rdata);
    wrt  = is_write;
    mode = port;
    dbo  = data;
    req  = 1'b1;
    next_cycle();
    while (ack !== 1'b1) begin
      next_cycle();
    end
    rdata = dbi;
    req   = 1'b0;
    next_cycle();
    while (ack !== 1'b0) begin
      next_cycle();
    end
  endtask

  task automatic read_and_check(input logic [1:0] port, input logic [7:0] expected);
    logic [7:0] got;
    exp_byte  = expected;
    exp_valid = 1'b1;
    bus_cycle(1'b0, port, 8'h00, got);
    exp_valid = 1'b0;
    reads_expected = reads_expected + 1;
  endtask

  task automatic wait_ce_clear();
    logic [7:0] status;
    status = 8'hff;
    while (status[vdp_reg_pkg::STAT_CE_BIT] !== 1'b0) begin
      bus_cycle(1'b0, 2'd1, 8'h00, status);
    end
  endtask

  initial begin
    int         a;
    int         i;
    int         idle;
    int         seed_ret;
    logic [3:0] op;
    logic [7:0] value;
    logic [7:0] unused;
    clk21m         = 1'b0;
    req            = 1'b0;
    wrt            = 1'b0;
    mode           = 2'd0;
    dbo            = 8'h00;
    exp_valid      = 1'b0;
    exp_byte       = 8'h00;
    reads_expected = 0;
    other_errors   = 0;
    // Fill pattern folds all address bits
    for (a = 0; a < (1 << vram_pkg::VRAM_AW); a++) begin
      vram_model[a] = a[7:0] ^ a[15:8] ^ {7'd0, a[16]};
    end
    $readmemh("vdp_stim.txt", stim);
    seed_ret = $urandom(SEED);
    #DRIVE_DELAY clk21m = 1'b1;
    repeat (RESET_CYCLES) @(posedge reset);
    #DRIVE_DELAY clk21m = 1'b0;

    for (i = 0; i < STIM_LINES; i++) begin
      op    = stim[i][15:12];
      value = stim[i][7:0];
      case (op)
        4'h1: bus_cycle(1'b1, stim[i][9:8], value, unused);
        4'h2: read_and_check(stim[i][9:8], value);
        4'h3: wait_ce_clear();
        default: begin
          other_errors = other_errors + 1;
          $display("Stimulus line %0d holds no known operation", i + 1);
        end
      endcase
      idle = $urandom % 4;
      repeat (idle) next_cycle();
    end

    repeat (4) next_cycle();
    if (check_count != reads_expected) begin
      other_errors = other_errors + 1;
      $display("Checker compared %0d reads but the stimulus holds %0d",
               check_count, reads_expected);
    end
    $display("Summary: %0d reads checked, %0d checker errors, %0d other errors",
             check_count, error_count, other_errors);
    if (error_count == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog, 4096 cycles per stimulus line
  initial begin
    #(STIM_LINES * 4096 * CLK_PERIOD);
    $display("Timeout: the stimulus did not complete within %0d cycles",
             STIM_LINES * 4096);
    $display("Summary: %0d reads checked, %0d checker errors, %0d other errors",
             check_count, error_count, other_errors + 1);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* vdp_stim.txt */
// One word per operation, digits: op, port, byte
// op 1 write byte, op 2 read and expect byte, op 3 poll status until CE is 0; port 0 data, 1 ctrl
// Reset state, CE clear
2100
// Address 0x01000 for write, three bytes, then back for read
1100
1150
10A5
105A
10C3
1100
1110
20A5
205A
20C3
// R14 = 1, write and read 0x11000
1101
118E
1100
1150
1077
1100
1110
2077
// R14 = 0, low bank keeps its byte
1100
118E
1100
1110
20A5
// HMMV with DX 4, DY 2, NX 8, NY 8, CLR EE
1104
11A4
1102
11A6
1108
11A8
1108
11AA
11EE
11AC
11C0
11AE
2101
// Reads outside the rectangle while the fill runs
1100
1110
20A5
205A
20C3
2101
3100
// Row 2 with both neighbours
1101
1101
2000
20EE
20EE
20EE
20EE
2007
// Last row, right neighbour and the byte below
1185
1104
20EE
2082
1105
1105
2000

/* list.f */
vram_pkg.sv
vdp_reg_pkg.sv
vram_req_if.sv
vdp_cpu_port.sv
vdp_fill_engine.sv
vram_arbiter.sv
vdp.sv
vdp_checker.sv
tb_vdp.sv
